// File: logic/mips_defines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// Datapath and address width.
`define MIPS_XLEN 32

// Instruction memory holds this many words.
`define IMEM_DEPTH 64

// Number of general purpose registers.
`define RF_DEPTH 32

// Primary opcodes of the supported subset.
`define OP_SPECIAL 6'h00
`define OP_REGIMM 6'h01
`define OP_J 6'h02
`define OP_JAL 6'h03
`define OP_BEQ 6'h04
`define OP_BNE 6'h05
`define OP_ADDIU 6'h09
// Ends a run.
`define OP_HALT 6'h3F

// Funct codes under OP_SPECIAL.
`define FN_JR 6'h08
`define FN_ADDU 6'h21

// Branch variants passed from decode to the jump unit.
`define BV_NONE 3'd0
`define BV_JUMP 3'd1
`define BV_JUMP_REG 3'd2
`define BV_JUMP_LINK 3'd3
`define BV_BEQ 3'd4
`define BV_BNE 3'd5
`define BV_BLTZ 3'd6

// APB address map.
`define APB_ADDR_W 12
`define APB_IMEM_BASE 12'h000
`define APB_REG_BASE 12'h100
`define APB_CTRL 12'h200
`define APB_STATUS 12'h204
`define APB_PC 12'h208
`define APB_COUNT 12'h20C

`endif

// File: logic/mips_pkg.sv
`include "mips_defines.svh"

package mips_pkg;

	// R format view.
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_format_t;

	// I format view.
	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm16;
	} i_format_t;

	// J format view.
	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] target26;
	} j_format_t;

	// One instruction word seen through all three formats.
	typedef union packed {
		r_format_t r;
		i_format_t i;
		j_format_t j;
	} instr_t;

	// Everything the jump unit needs to resolve control flow.
	typedef struct packed {
		logic [2:0]            branch_variant;
		logic [`MIPS_XLEN-1:0] maybe_jump_address;
		logic [`MIPS_XLEN-1:0] maybe_branch_address;
		logic [`MIPS_XLEN-1:0] pc_plus_four;
	} jump_req_t;

	// Resolved control flow and the link write.
	typedef struct packed {
		logic                  pc_src;
		logic [`MIPS_XLEN-1:0] jump_address;
		logic                  branch;
		logic                  ra_write;
		logic [`MIPS_XLEN-1:0] ra_write_value;
	} jump_res_t;

	// Host side register file access.
	typedef struct packed {
		logic                  we;
		logic [4:0]            addr;
		logic [`MIPS_XLEN-1:0] wdata;
	} rf_host_t;

endpackage

// File: logic/decoder.sv
`timescale 1ns/10ps

`include "mips_defines.svh"

// Splits the instruction word into register selects, the ALU write and the jump request.
module decoder (
	input  mips_pkg::instr_t         instr,
	input  logic [`MIPS_XLEN-1:0]    pc_plus_four,
	input  logic [`MIPS_XLEN-1:0]    reg_rs,
	input  logic [`MIPS_XLEN-1:0]    reg_rt,
	output logic [4:0]               rs_sel,
	output logic [4:0]               rt_sel,
	output logic                     alu_we,
	output logic [4:0]               alu_waddr,
	output logic [`MIPS_XLEN-1:0]    alu_wdata,
	output mips_pkg::jump_req_t      jump_req
);

	// Sign extended immediate for ADDIU and the branch offset.
	logic [`MIPS_XLEN-1:0] imm_sext;

	assign imm_sext = {{(`MIPS_XLEN-16){instr.i.imm16[15]}}, instr.i.imm16};

	// The rs and rt fields sit in the same place in the R and I views.
	assign rs_sel = instr.r.rs;
	assign rt_sel = instr.r.rt;

	// Branch target is relative to the next word.
	assign jump_req.maybe_branch_address = pc_plus_four + (imm_sext << 2);

	// Jump target stays inside the current 256 MB region.
	assign jump_req.maybe_jump_address = {pc_plus_four[31:28], instr.j.target26, 2'b00};

	assign jump_req.pc_plus_four = pc_plus_four;

	always_comb begin
		// Unknown opcodes and HALT fall through as no-ops.
		alu_we = 1'b0;
		alu_waddr = instr.r.rd;
		alu_wdata = reg_rs + reg_rt;
		jump_req.branch_variant = `BV_NONE;
		case (instr.r.opcode)
			`OP_SPECIAL: begin
				case (instr.r.funct)
					`FN_ADDU: alu_we = 1'b1;
					`FN_JR: jump_req.branch_variant = `BV_JUMP_REG;
					default: ;
				endcase
			end
			`OP_ADDIU: begin
				// I format writes rt, not rd.
				alu_we = 1'b1;
				alu_waddr = instr.i.rt;
				alu_wdata = reg_rs + imm_sext;
			end
			`OP_BEQ: jump_req.branch_variant = `BV_BEQ;
			`OP_BNE: jump_req.branch_variant = `BV_BNE;
			`OP_REGIMM: begin
				// Only rt of zero (BLTZ) is supported under REGIMM.
				if (instr.i.rt == 5'd0)
					jump_req.branch_variant = `BV_BLTZ;
			end
			`OP_J: jump_req.branch_variant = `BV_JUMP;
			`OP_JAL: jump_req.branch_variant = `BV_JUMP_LINK;
			default: ;
		endcase
	end

endmodule

// File: logic/register_file.sv
`timescale 1ns/10ps

`include "mips_defines.svh"

// General purpose registers with two core read ports and a host port.
module register_file (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic [4:0]            rs_sel,
	input  logic [4:0]            rt_sel,
	output logic [`MIPS_XLEN-1:0] reg_rs,
	output logic [`MIPS_XLEN-1:0] reg_rt,
	input  logic                  alu_we,
	input  logic [4:0]            alu_waddr,
	input  logic [`MIPS_XLEN-1:0] alu_wdata,
	input  logic                  ra_write,
	input  logic [`MIPS_XLEN-1:0] ra_write_value,
	input  mips_pkg::rf_host_t    host,
	output logic [`MIPS_XLEN-1:0] host_rdata
);

	logic [`MIPS_XLEN-1:0] regs [`RF_DEPTH];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `RF_DEPTH; i++)
				regs[i] <= '0;
		end else begin
			// Host and core writes never overlap since the host is locked out while busy.
			if (host.we && host.addr != 5'd0)
				regs[host.addr] <= host.wdata;
			if (alu_we && alu_waddr != 5'd0)
				regs[alu_waddr] <= alu_wdata;
			// JAL link goes to r31.
			if (ra_write)
				regs[31] <= ra_write_value;
		end
	end

	// r0 reads as zero.
	assign reg_rs = (rs_sel == 5'd0) ? '0 : regs[rs_sel];
	assign reg_rt = (rt_sel == 5'd0) ? '0 : regs[rt_sel];
	assign host_rdata = (host.addr == 5'd0) ? '0 : regs[host.addr];

endmodule

// File: logic/jump_unit.sv
`timescale 1ns/10ps

`include "mips_defines.svh"

// Decides whether the PC jumps and where it goes.
module jump_unit (
	input  mips_pkg::jump_req_t   jump_req,
	input  logic [`MIPS_XLEN-1:0] reg_rs,
	input  logic [`MIPS_XLEN-1:0] reg_rt,
	output mips_pkg::jump_res_t   jump_res
);

	// Any variant other than none is a control-flow instruction.
	assign jump_res.branch = (jump_req.branch_variant != `BV_NONE);

	// Only JAL links.
	assign jump_res.ra_write = (jump_req.branch_variant == `BV_JUMP_LINK);
	assign jump_res.ra_write_value = jump_req.pc_plus_four;

	always_comb begin
		case (jump_req.branch_variant)
			`BV_JUMP,
			`BV_JUMP_LINK: begin
				jump_res.pc_src = 1'b1;
				jump_res.jump_address = jump_req.maybe_jump_address;
			end
			`BV_JUMP_REG: begin
				// JR target comes straight from rs.
				jump_res.pc_src = 1'b1;
				jump_res.jump_address = reg_rs;
			end
			`BV_BEQ: begin
				jump_res.pc_src = (reg_rs == reg_rt);
				jump_res.jump_address = jump_req.maybe_branch_address;
			end
			`BV_BNE: begin
				jump_res.pc_src = (reg_rs != reg_rt);
				jump_res.jump_address = jump_req.maybe_branch_address;
			end
			`BV_BLTZ: begin
				// Sign test of rs.
				jump_res.pc_src = ($signed(reg_rs) < 0);
				jump_res.jump_address = jump_req.maybe_branch_address;
			end
			default: begin
				// Not taken with a zero address.
				jump_res.pc_src = 1'b0;
				jump_res.jump_address = '0;
			end
		endcase
	end

endmodule

// File: logic/fetch_unit.sv
`timescale 1ns/10ps

`include "mips_defines.svh"

// PC, instruction memory and the run/halt control.
module fetch_unit (
	input  logic                             clk,
	input  logic                             arst_n,
	input  logic                             imem_we,
	input  logic [$clog2(`IMEM_DEPTH)-1:0]   imem_addr,
	input  logic [`MIPS_XLEN-1:0]            imem_wdata,
	input  logic                             run_start,
	input  mips_pkg::jump_res_t              jump_res,
	output mips_pkg::instr_t                 instr,
	output logic [`MIPS_XLEN-1:0]            pc_plus_four,
	output logic                             busy,
	output logic [`MIPS_XLEN-1:0]            pc,
	output logic [`MIPS_XLEN-1:0]            retired
);

	import mips_pkg::*;

	localparam int IMEM_AW = $clog2(`IMEM_DEPTH);

	// Shown to the decoder while idle so nothing gets written.
	localparam instr_t HALT_WORD = {`OP_HALT, 26'd0};

	logic [`MIPS_XLEN-1:0] imem [`IMEM_DEPTH];
	instr_t fetched;
	logic is_halt;

	// Host loads the program through APB.
	always_ff @(posedge clk) begin
		if (imem_we)
			imem[imem_addr] <= imem_wdata;
	end

	// Word addressed fetch.
	assign fetched = imem[pc[IMEM_AW+1:2]];
	assign is_halt = (fetched.j.opcode == `OP_HALT);

	assign instr = busy ? fetched : HALT_WORD;
	assign pc_plus_four = pc + `MIPS_XLEN'd4;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			pc <= '0;
			retired <= '0;
		end else if (!busy) begin
			// Idle. A start restarts the program from address 0.
			if (run_start) begin
				busy <= 1'b1;
				pc <= '0;
				retired <= '0;
			end
		end else if (is_halt) begin
			// PC parks on the HALT and HALT is not counted.
			busy <= 1'b0;
		end else begin
			pc <= jump_res.pc_src ? jump_res.jump_address : pc_plus_four;
			retired <= retired + 1'b1;
		end
	end

endmodule

// File: logic/apb_host_port.sv
`timescale 1ns/10ps

`include "mips_defines.svh"

// APB slave for program load, register access, run control and status.
module apb_host_port (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    psel,
	input  logic                    penable,
	input  logic                    pwrite,
	input  logic [`APB_ADDR_W-1:0]  paddr,
	input  logic [`MIPS_XLEN-1:0]   pwdata,
	output logic [`MIPS_XLEN-1:0]   prdata,
	output logic                    pready,
	output logic                    pslverr,
	input  logic                    busy,
	input  logic [`MIPS_XLEN-1:0]   pc,
	input  logic [`MIPS_XLEN-1:0]   retired,
	input  logic [`MIPS_XLEN-1:0]   host_rdata,
	output logic                    imem_we,
	output logic [5:0]              imem_addr,
	output logic [`MIPS_XLEN-1:0]   imem_wdata,
	output logic                    run_start,
	output mips_pkg::rf_host_t      host
);

	logic access;
	logic aligned;
	logic is_imem;
	logic is_reg;
	logic is_ctrl;
	logic is_status;
	logic is_pc;
	logic is_count;
	logic mapped;
	logic err;
	logic write_ok;

	// No wait states.
	assign pready = 1'b1;
	assign access = psel & penable;

	// Address decode. Only word aligned addresses are mapped.
	assign aligned = (paddr[1:0] == 2'b00);
	assign is_imem = aligned && paddr >= `APB_IMEM_BASE && paddr < `APB_IMEM_BASE + 4 * `IMEM_DEPTH;
	assign is_reg = aligned && paddr >= `APB_REG_BASE && paddr < `APB_REG_BASE + 4 * `RF_DEPTH;
	assign is_ctrl = (paddr == `APB_CTRL);
	assign is_status = (paddr == `APB_STATUS);
	assign is_pc = (paddr == `APB_PC);
	assign is_count = (paddr == `APB_COUNT);
	assign mapped = is_imem | is_reg | is_ctrl | is_status | is_pc | is_count;

	// Program and registers are locked while a run is in flight.
	// Instruction memory is write only.
	assign err = !mapped | (pwrite & busy & (is_imem | is_reg)) | (!pwrite & is_imem);
	assign pslverr = access & err;
	assign write_ok = access & pwrite & !err;

	assign imem_we = write_ok & is_imem;
	assign imem_addr = paddr[7:2];
	assign imem_wdata = pwdata;

	// Host port address also drives the read mux in the register file.
	assign host.we = write_ok & is_reg;
	assign host.addr = paddr[6:2];
	assign host.wdata = pwdata;

	// Start pulse is one cycle after the CTRL write completes.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			run_start <= 1'b0;
		else
			run_start <= write_ok & is_ctrl & pwdata[0];
	end

	always_comb begin
		prdata = '0;
		if (is_reg)
			prdata = host_rdata;
		else if (is_status)
			prdata = {{(`MIPS_XLEN-1){1'b0}}, busy};
		else if (is_pc)
			prdata = pc;
		else if (is_count)
			prdata = retired;
	end

endmodule

// File: logic/mips_core.sv
`timescale 1ns/10ps

`include "mips_defines.svh"

// Single cycle control-flow core with an APB host port.
module mips_core (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [`APB_ADDR_W-1:0] paddr,
	input  logic [`MIPS_XLEN-1:0]  pwdata,
	output logic [`MIPS_XLEN-1:0]  prdata,
	output logic                   pready,
	output logic                   pslverr
);

	import mips_pkg::*;

	// Host side.
	logic imem_we;
	logic [5:0] imem_addr;
	logic [`MIPS_XLEN-1:0] imem_wdata;
	logic run_start;
	rf_host_t host;
	logic [`MIPS_XLEN-1:0] host_rdata;

	// Fetch and status.
	logic busy;
	logic [`MIPS_XLEN-1:0] pc;
	logic [`MIPS_XLEN-1:0] retired;
	logic [`MIPS_XLEN-1:0] pc_plus_four;
	instr_t instr;

	// Decode and register reads.
	logic [4:0] rs_sel;
	logic [4:0] rt_sel;
	logic [`MIPS_XLEN-1:0] reg_rs;
	logic [`MIPS_XLEN-1:0] reg_rt;
	logic alu_we;
	logic [4:0] alu_waddr;
	logic [`MIPS_XLEN-1:0] alu_wdata;

	// Control flow.
	jump_req_t jump_req;
	jump_res_t jump_res;

	apb_host_port u_apb_host_port (
		.clk(clk), .arst_n(arst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.busy(busy), .pc(pc), .retired(retired), .host_rdata(host_rdata),
		.imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
		.run_start(run_start), .host(host)
	);

	fetch_unit u_fetch_unit (
		.clk(clk), .arst_n(arst_n),
		.imem_we(imem_we), .imem_addr(imem_addr), .imem_wdata(imem_wdata),
		.run_start(run_start), .jump_res(jump_res),
		.instr(instr), .pc_plus_four(pc_plus_four),
		.busy(busy), .pc(pc), .retired(retired)
	);

	decoder u_decoder (
		.instr(instr), .pc_plus_four(pc_plus_four),
		.reg_rs(reg_rs), .reg_rt(reg_rt),
		.rs_sel(rs_sel), .rt_sel(rt_sel),
		.alu_we(alu_we), .alu_waddr(alu_waddr), .alu_wdata(alu_wdata),
		.jump_req(jump_req)
	);

	register_file u_register_file (
		.clk(clk), .arst_n(arst_n),
		.rs_sel(rs_sel), .rt_sel(rt_sel), .reg_rs(reg_rs), .reg_rt(reg_rt),
		.alu_we(alu_we), .alu_waddr(alu_waddr), .alu_wdata(alu_wdata),
		.ra_write(jump_res.ra_write), .ra_write_value(jump_res.ra_write_value),
		.host(host), .host_rdata(host_rdata)
	);

	jump_unit u_jump_unit (
		.jump_req(jump_req),
		.reg_rs(reg_rs), .reg_rt(reg_rt),
		.jump_res(jump_res)
	);

endmodule

// File: verif/tb_clock_gen.sv
`timescale 1ns/10ps

// Free running clock and power-on reset for the testbench.
module tb_clock_gen (
	output logic clk,
	output logic arst_n
);

	// 20 ns period.
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Reset held low over the first four rising edges.
	initial begin
		arst_n = 1'b0;
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;
	end

endmodule

// File: verif/mips_core_sva.sv
`timescale 1ns/10ps

`include "mips_defines.svh"

// Control-flow and APB properties of the core.
module mips_core_sva (
	input logic                  clk,
	input logic                  arst_n,
	input logic                  psel,
	input logic                  penable,
	input logic                  pslverr,
	input logic                  imem_we,
	input mips_pkg::rf_host_t    host,
	input logic [`MIPS_XLEN-1:0] pc,
	input mips_pkg::instr_t      instr,
	input mips_pkg::jump_res_t   jump_res
);

	// A taken transfer comes from a control-flow variant and lands the PC on its target.
	a_pc_src_branch: assert property (@(posedge clk) disable iff (!arst_n)
		jump_res.pc_src |=> ($past(jump_res.branch) && pc == $past(jump_res.jump_address)))
		else $error("taken control transfer did not reach its target");

	// Only JAL writes the link register, and the link is the word after the JAL.
	a_ra_write_link: assert property (@(posedge clk) disable iff (!arst_n)
		jump_res.ra_write |->
			(instr.j.opcode == `OP_JAL && jump_res.ra_write_value == pc + 32'd4))
		else $error("ra_write raised outside a JAL or with a wrong link value");

	// Errors belong to the access phase and the refused write goes nowhere.
	a_pslverr_access: assert property (@(posedge clk) disable iff (!arst_n)
		pslverr |-> (psel && penable && !imem_we && !host.we))
		else $error("pslverr outside an access cycle or with a write let through");

endmodule

// Checker on the core's control-flow and APB wires.
bind mips_core mips_core_sva u_mips_core_sva (
	.clk(clk),
	.arst_n(arst_n),
	.psel(psel),
	.penable(penable),
	.pslverr(pslverr),
	.imem_we(imem_we),
	.host(host),
	.pc(pc),
	.instr(instr),
	.jump_res(jump_res)
);

// File: verif/tb_mips_core.sv
`timescale 1ns/10ps

`include "mips_defines.svh"

// Random-program testbench with an ISA reference model.
module tb_mips_core;

	// Runs in the whole test list, counting the register round-trip as one.
	localparam int RUN_COUNT = 33;
	// APB cycles per run for load, start, polls and readout.
	localparam int APB_CYCLES = 500;
	localparam longint TIMEOUT_NS = 64'(RUN_COUNT) * (`IMEM_DEPTH + APB_CYCLES) * 20;

	// Slot kinds of a generated program.
	localparam int K_ADDU = 0;
	localparam int K_ADDIU = 1;
	localparam int K_BEQ = 2;
	localparam int K_BNE = 3;
	localparam int K_BLTZ = 4;
	localparam int K_J = 5;
	localparam int K_JAL = 6;
	localparam int K_JR = 7;
	localparam int K_LOAD = 8;
	localparam int K_HALT = 9;

	logic clk;
	logic arst_n;
	logic psel;
	logic penable;
	logic pwrite;
	logic [`APB_ADDR_W-1:0] paddr;
	logic [`MIPS_XLEN-1:0] pwdata;
	logic [`MIPS_XLEN-1:0] prdata;
	logic pready;
	logic pslverr;

	integer seed = 32'h6d155919;
	logic [31:0] prog [`IMEM_DEPTH];
	int slot_kind [`IMEM_DEPTH];
	// Architectural state predicted by the model.
	logic [31:0] model_regs [32];
	logic [31:0] model_pc;
	logic [31:0] model_count;
	string test_name;
	int errors;
	int checks;
	int tests;
	int failed_tests;
	int test_start_errors;

	tb_clock_gen u_clock_gen (.clk(clk), .arst_n(arst_n));

	mips_core u_mips_core (
		.clk(clk), .arst_n(arst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

	function automatic int rand_below(int m);
		return $unsigned($random(seed)) % m;
	endfunction

	task automatic check_value(input string what, input logic [31:0] exp,
			input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			$display("Fail %s: %s expected %h, actual %h", test_name, what, exp, act);
			errors++;
		end
	endtask

	// One APB transfer, setup then access.
	task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic err);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= wr;
		paddr <= addr;
		pwdata <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		// Sampled half a cycle before the access completes.
		@(negedge clk);
		rdata = prdata;
		err = pslverr;
		// Every access completes without wait states.
		check_value("pready", 32'd1, {31'd0, pready});
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic bus_write(input logic [11:0] addr, input logic [31:0] data);
		logic [31:0] rdata;
		logic err;
		apb_xfer(1'b1, addr, data, rdata, err);
		check_value("pslverr", 32'd0, {31'd0, err});
	endtask

	task automatic bus_read(input logic [11:0] addr, output logic [31:0] data);
		logic err;
		apb_xfer(1'b0, addr, 32'd0, data, err);
		check_value("pslverr", 32'd0, {31'd0, err});
	endtask

	task automatic bus_expect_error(input logic wr, input logic [11:0] addr,
			input logic [31:0] data);
		logic [31:0] rdata;
		logic err;
		apb_xfer(wr, addr, data, rdata, err);
		check_value("pslverr", 32'd1, {31'd0, err});
	endtask

	// Random forward target that never lands on a JR without its address load.
	function automatic int pick_target(int k, int n);
		int t;
		t = k + 1 + rand_below(n - k);
		while (slot_kind[t] == K_JR)
			t++;
		return t;
	endfunction

	// Class 0 is ALU only, 1 adds branches, 2 adds jumps, 3 mixes all.
	task automatic gen_program(input int cls);
		int n;
		int k;
		int kind;
		int t;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] rx;
		n = 6 + rand_below(`IMEM_DEPTH - 8);
		for (int i = 0; i < `IMEM_DEPTH; i++) begin
			slot_kind[i] = K_HALT;
			prog[i] = {`OP_HALT, 26'd0};
		end
		// Kinds first, so targets can skip JR slots.
		k = 0;
		while (k < n) begin
			case (cls)
				0: kind = rand_below(2);
				1: kind = rand_below(5);
				2: kind = rand_below(5) + 3;
				default: kind = rand_below(8);
			endcase
			if (cls == 2 && kind < 5)
				kind = kind - 3;
			if (kind == K_JR && k + 1 < n) begin
				slot_kind[k] = K_LOAD;
				slot_kind[k + 1] = K_JR;
				k = k + 2;
			end else begin
				slot_kind[k] = (kind == K_JR) ? K_ADDU : kind;
				k++;
			end
		end
		for (int i = 0; i < n; i++) begin
			rs = 5'(rand_below(32));
			// Equal operands half the time so BEQ gets taken.
			rt = rand_below(2) ? rs : 5'(rand_below(32));
			rd = 5'(rand_below(32));
			rx = 5'(1 + rand_below(31));
			t = pick_target(i, n);
			case (slot_kind[i])
				K_ADDU: prog[i] = {`OP_SPECIAL, rs, rt, rd, 5'd0, `FN_ADDU};
				K_ADDIU: prog[i] = {`OP_ADDIU, rs, rd, 16'($random(seed))};
				K_BEQ: prog[i] = {`OP_BEQ, rs, rt, 16'(t - i - 1)};
				K_BNE: prog[i] = {`OP_BNE, rs, rt, 16'(t - i - 1)};
				K_BLTZ: prog[i] = {`OP_REGIMM, rs, 5'd0, 16'(t - i - 1)};
				K_J: prog[i] = {`OP_J, 26'(t)};
				K_JAL: prog[i] = {`OP_JAL, 26'(t)};
				K_LOAD: prog[i] = {`OP_ADDIU, 5'd0, rx, 16'(4 * t)};
				K_JR: prog[i] = {`OP_SPECIAL, prog[i - 1][20:16], 15'd0, `FN_JR};
				default: ;
			endcase
		end
	endtask

	task automatic load_program();
		for (int i = 0; i < `IMEM_DEPTH; i++)
			bus_write(`APB_IMEM_BASE + 12'(4 * i), prog[i]);
	endtask

	task automatic start_run();
		bus_write(`APB_CTRL, 32'd1);
	endtask

	// Polls STATUS until busy falls.
	task automatic wait_idle();
		logic [31:0] status;
		int polls;
		polls = 0;
		status = 32'd1;
		while (status[0] && polls < 200) begin
			bus_read(`APB_STATUS, status);
			polls++;
		end
		if (status[0]) begin
			$display("Error %s: busy still high after %0d status reads", test_name, polls);
			errors++;
		end
	endtask

	// Executes prog from address 0 up to the first HALT.
	task automatic run_model();
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] npc;
		int steps;
		model_pc = 32'd0;
		model_count = 32'd0;
		steps = 0;
		w = prog[0];
		while (w[31:26] != `OP_HALT && steps < 1000) begin
			a = model_regs[w[25:21]];
			b = model_regs[w[20:16]];
			imm = {{16{w[15]}}, w[15:0]};
			npc = model_pc + 32'd4;
			case (w[31:26])
				`OP_SPECIAL: begin
					if (w[5:0] == `FN_ADDU)
						model_regs[w[15:11]] = a + b;
					else if (w[5:0] == `FN_JR)
						npc = a;
				end
				`OP_ADDIU: model_regs[w[20:16]] = a + imm;
				`OP_BEQ: begin
					if (a == b)
						npc = model_pc + 32'd4 + (imm << 2);
				end
				`OP_BNE: begin
					if (a != b)
						npc = model_pc + 32'd4 + (imm << 2);
				end
				`OP_REGIMM: begin
					if (w[20:16] == 5'd0 && a[31])
						npc = model_pc + 32'd4 + (imm << 2);
				end
				`OP_J: npc = {npc[31:28], w[25:0], 2'b00};
				`OP_JAL: begin
					model_regs[31] = model_pc + 32'd4;
					npc = {npc[31:28], w[25:0], 2'b00};
				end
				default: ;
			endcase
			model_regs[0] = 32'd0;
			model_pc = npc;
			model_count++;
			steps++;
			w = prog[model_pc[7:2]];
		end
	endtask

	task automatic check_state();
		logic [31:0] value;
		for (int r = 0; r < 32; r++) begin
			bus_read(`APB_REG_BASE + 12'(4 * r), value);
			check_value($sformatf("r%0d", r), model_regs[r], value);
		end
		bus_read(`APB_PC, value);
		check_value("pc", model_pc, value);
		bus_read(`APB_COUNT, value);
		check_value("count", model_count, value);
	endtask

	task automatic run_program(input int cls);
		gen_program(cls);
		load_program();
		start_run();
		wait_idle();
		run_model();
		check_state();
	endtask

	// 40 ADDIU into r1..r4, then HALT. Refused accesses land while it runs.
	task automatic bus_error_test();
		for (int i = 0; i < `IMEM_DEPTH; i++) begin
			if (i < 40)
				prog[i] = {`OP_ADDIU, 5'(rand_below(32)), 5'(1 + rand_below(4)),
					16'($random(seed))};
			else
				prog[i] = {`OP_HALT, 26'd0};
		end
		load_program();
		start_run();
		bus_expect_error(1'b1, `APB_REG_BASE + 12'd20, 32'hdead_beef);
		bus_expect_error(1'b1, `APB_IMEM_BASE + 12'd160, {`OP_ADDIU, 5'd0, 5'd6, 16'h1234});
		bus_expect_error(1'b0, `APB_IMEM_BASE, 32'd0);
		bus_expect_error(1'b1, 12'h300, 32'd1);
		wait_idle();
		run_model();
		check_state();
		// Still refused when idle.
		bus_expect_error(1'b0, `APB_IMEM_BASE + 12'h010, 32'd0);
		bus_expect_error(1'b1, 12'hffc, 32'hffff_ffff);
		check_state();
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_start_errors = errors;
	endtask

	task automatic end_test();
		tests++;
		if (errors == test_start_errors) begin
			$display("%s: ok", test_name);
		end else begin
			failed_tests++;
			$display("%s: %0d mismatches", test_name, errors - test_start_errors);
		end
	endtask

	initial begin
		logic [31:0] value;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		errors = 0;
		checks = 0;
		tests = 0;
		failed_tests = 0;
		model_pc = 32'd0;
		model_count = 32'd0;
		for (int r = 0; r < 32; r++)
			model_regs[r] = 32'd0;
		@(posedge arst_n);

		begin_test("reg_roundtrip");
		bus_read(`APB_STATUS, value);
		check_value("status", 32'd0, value);
		for (int r = 0; r < 32; r++) begin
			value = $random(seed);
			bus_write(`APB_REG_BASE + 12'(4 * r), value);
			// r0 drops the write.
			if (r != 0)
				model_regs[r] = value;
		end
		check_state();
		end_test();

		begin_test("alu_programs");
		repeat (3) run_program(0);
		end_test();

		begin_test("branch_programs");
		repeat (4) run_program(1);
		end_test();

		begin_test("jump_programs");
		repeat (4) run_program(2);
		end_test();

		begin_test("bus_errors");
		bus_error_test();
		end_test();

		begin_test("random_mixed");
		repeat (20) run_program(3);
		end_test();

		$display("summary: %0d tests, %0d failing, %0d checks, %0d mismatches",
			tests, failed_tests, checks, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	// Watchdog sized from the run count and the APB traffic per run.
	initial begin
		#(TIMEOUT_NS);
		$display("watchdog expired after %0d ns before the tests finished", TIMEOUT_NS);
		$display("test failed");
		$finish;
	end

endmodule

// File: tb.f
+incdir+logic
logic/mips_pkg.sv
logic/decoder.sv
logic/register_file.sv
logic/jump_unit.sv
logic/fetch_unit.sv
logic/apb_host_port.sv
logic/mips_core.sv
verif/tb_clock_gen.sv
verif/mips_core_sva.sv
verif/tb_mips_core.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and scans the log.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_mips_core -f tb.f -o Vtb_mips_core

./obj_dir/Vtb_mips_core 2>&1 | tee sim.log

if grep -q "test failed" sim.log; then
	exit 1
fi
